// File: bench/cache_axi_read_properties.sv
`timescale 1ns/1ps
/* Protocol checks bound into the bridge top level */
module cache_axi_read_properties
  import mem_req_pkg::*;
  import axi_rd_pkg::*;
(
  input logic    clk_i,
  input logic    rst_ni,
  input logic    axi_ar_valid_o,
  input logic    axi_ar_ready_i,
  input axi_ar_t axi_ar_o,
  input logic    dcache_miss_resp_valid_o,
  input logic    icache_miss_resp_valid_o,
  input logic    fifo_valid
);

  // Failed assertion count
  int unsigned fail_count = 0;

  // AR word must hold while stalled
  ar_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    axi_ar_valid_o && !axi_ar_ready_i |=> $stable(axi_ar_o))
    else begin
      fail_count++;
      $error("AR word changed while valid and not ready");
    end

  ic_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    icache_miss_resp_valid_o |=> !icache_miss_resp_valid_o)
    else begin
      fail_count++;
      $error("icache response valid high for two cycles");
    end

  reset_quiet: assert property (@(posedge clk_i)
    !rst_ni |=> !(axi_ar_valid_o || dcache_miss_resp_valid_o ||
                  icache_miss_resp_valid_o || fifo_valid))
    else begin
      fail_count++;
      $error("valid output high right after reset");
    end

endmodule

bind cache_axi_read_top cache_axi_read_properties u_props (
  .clk_i                    (clk_i),
  .rst_ni                   (rst_ni),
  .axi_ar_valid_o           (axi_ar_valid_o),
  .axi_ar_ready_i           (axi_ar_ready_i),
  .axi_ar_o                 (axi_ar_o),
  .dcache_miss_resp_valid_o (dcache_miss_resp_valid_o),
  .icache_miss_resp_valid_o (icache_miss_resp_valid_o),
  .fifo_valid               (fifo_valid)
);

// File: bench/read_golden.txt
# src addr(hex) id(hex) len stall word0 word1 word2 word3 (first 32-bit word per beat)
# stall 1 delays issue a few cycles; unused words are 0; addr bit 12 set means SLVERR
I 0000000100 F 3 0 00000100 00000110 00000120 00000130
D 0000002000 1 1 0 00002000 00002010 00000000 00000000
I 0000000200 F 3 0 00000200 00000210 00000220 00000230
D 0000002040 2 3 0 00002040 00002050 00002060 00002070
I 0000000300 F 3 0 00000300 00000310 00000320 00000330
D 0000002080 3 0 0 00002080 00000000 00000000 00000000
I 0000000400 F 3 0 00000400 00000410 00000420 00000430
D 00000020c0 4 2 0 000020c0 000020d0 000020e0 00000000
I 0000001500 F 3 1 00001500 00001510 00001520 00001530
D 0000003000 5 1 1 00003000 00003010 00000000 00000000
I 0000000a00 F 3 1 00000a00 00000a10 00000a20 00000a30
D 0000004100 6 3 1 00004100 00004110 00004120 00004130
D 0000004200 7 0 1 00004200 00000000 00000000 00000000
I 0000000b00 F 3 0 00000b00 00000b10 00000b20 00000b30
D 000000ffe0 8 1 0 0000ffe0 0000fff0 00000000 00000000
I 12345678c0 F 3 0 345678c0 345678d0 345678e0 345678f0
D 00fffffff0 9 1 0 fffffff0 00000000 00000000 00000000
D 0000000800 a 2 1 00000800 00000810 00000820 00000000
I 0000000c00 F 3 1 00000c00 00000c10 00000c20 00000c30
D 0000000900 0 3 0 00000900 00000910 00000920 00000930
I 0000000d00 F 3 0 00000d00 00000d10 00000d20 00000d30
D 0000000e00 b 0 0 00000e00 00000000 00000000 00000000
I 0000002f00 F 3 0 00002f00 00002f10 00002f20 00002f30
D 0000005000 c 3 1 00005000 00005010 00005020 00005030
I 0000000e40 F 3 1 00000e40 00000e50 00000e60 00000e70
D 0000006000 d 1 0 00006000 00006010 00000000 00000000

// File: bench/tb_clk_gen.sv
`timescale 1ns/1ps
/* 10 ns clock; reset held low for the first 2 rising edges */
module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule

// File: bench/tb_top.sv
`timescale 1ns/1ps
/* Golden-file testbench with an in-order AXI read memory model.
   Beat k at address A returns low 32 bits of A+16k in every word; A[12] gives SLVERR. */
module tb_top
  import mem_req_pkg::*;
  import axi_rd_pkg::*;
();

  logic clk, rst_n;
  logic icache_miss_valid_i, icache_miss_ready_o;
  logic [PADDR_W-1:0] icache_miss_paddr_i;
  logic dcache_miss_valid_i, dcache_miss_ready_o;
  mem_req_t dcache_miss_req_i;
  logic axi_ar_valid_o, axi_ar_ready_i, axi_r_valid_i, axi_r_ready_o;
  axi_ar_t axi_ar_o;
  axi_r_t axi_r_i;
  logic dcache_miss_resp_valid_o, dcache_miss_resp_ready_i;
  mem_resp_r_t dcache_miss_resp_o;
  logic icache_miss_resp_valid_o, icache_miss_resp_err_o;
  ifill_line_t icache_miss_resp_data_o;

  // Golden table
  logic [39:0] ga [64];
  logic [3:0] gid [64];
  int glen [64];
  int gstl [64];
  logic [31:0] gw [64][4];
  int d_list[$], i_list[$];
  int n_lines = 0, errors = 0;
  bit golden_loaded = 0;
  int i_ar = 0, d_ar = 0, i_rsp = 0, d_rsp = 0, d_beat = 0, want_src = 0;

  // Memory model state
  logic [39:0] bq_addr[$];
  logic [3:0] bq_id[$];
  int bq_len[$];
  int beat = 0;
  bit r_fired = 0;

  tb_clk_gen u_clk (.clk_o(clk), .rst_no(rst_n));

  cache_axi_read_top uut (.clk_i(clk), .rst_ni(rst_n), .*);

  task automatic mismatch(input string name, input logic [511:0] got, input logic [511:0] exp);
    errors++;
    $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
  endtask

  task automatic fail_note(input string what);
    errors++;
    $display("Error at %0t: %s", $time, what);
  endtask

  task automatic drive_icache();
    int idx;
    for (int n = 0; n < i_list.size(); n++) begin
      idx = i_list[n];
      if (gstl[idx] != 0) repeat ($urandom_range(4, 1)) @(negedge clk);
      icache_miss_valid_i = 1'b1;
      icache_miss_paddr_i = ga[idx];
      do @(posedge clk); while (!icache_miss_ready_o);
      @(negedge clk);
      icache_miss_valid_i = 1'b0;
    end
  endtask

  task automatic drive_dcache();
    int idx;
    for (int n = 0; n < d_list.size(); n++) begin
      idx = d_list[n];
      if (gstl[idx] != 0) repeat ($urandom_range(4, 1)) @(negedge clk);
      dcache_miss_valid_i = 1'b1;
      dcache_miss_req_i = '{addr: ga[idx], len: 4'(glen[idx]), size: AXI_SIZE_BEAT, id: gid[idx]};
      do @(posedge clk); while (!dcache_miss_ready_o);
      @(negedge clk);
      dcache_miss_valid_i = 1'b0;
    end
  endtask

  // AR acceptance and R beat handshakes
  always @(posedge clk) begin
    if (rst_n && axi_ar_valid_o && axi_ar_ready_i) begin
      bq_addr.push_back(axi_ar_o.addr);
      bq_id.push_back(axi_ar_o.id);
      bq_len.push_back(int'(axi_ar_o.len));
    end
    if (rst_n && axi_r_valid_i && axi_r_ready_o) r_fired = 1'b1;
  end

  // Random ready and valid gaps
  always @(negedge clk) begin
    if (r_fired) begin
      r_fired = 1'b0;
      axi_r_valid_i = 1'b0;
      if (beat == bq_len[0]) begin
        void'(bq_addr.pop_front());
        void'(bq_id.pop_front());
        void'(bq_len.pop_front());
        beat = 0;
      end else begin
        beat++;
      end
    end
    if (!axi_r_valid_i && bq_addr.size() > 0 && $urandom_range(3, 0) != 0) begin
      axi_r_valid_i = 1'b1;
      axi_r_i.id = bq_id[0];
      axi_r_i.data = {4{bq_addr[0][31:0] + 32'(16 * beat)}};
      axi_r_i.resp = bq_addr[0][12] ? 2'b10 : AXI_RESP_OKAY;
      axi_r_i.last = (beat == bq_len[0]);
    end
    axi_ar_ready_i = ($urandom_range(3, 0) != 0);
    dcache_miss_resp_ready_i = ($urandom_range(3, 0) != 0);
  end

  always @(posedge clk) begin : check_outputs
    int idx;
    logic src_ic;
    ifill_line_t line;
    if (rst_n && axi_ar_valid_o && axi_ar_ready_i) begin
      src_ic = (axi_ar_o.id == ICACHE_MEM_ID);
      if (want_src != 0 && want_src != (src_ic ? 1 : 2))
        fail_note("AR granted the same source twice while the other waited");
      want_src = 0;
      if (src_ic && dcache_miss_valid_i) want_src = 2;
      if (!src_ic && !icache_miss_ready_o) want_src = 1;
      if (axi_ar_o.size !== AXI_SIZE_BEAT) mismatch("axi_ar_o.size", axi_ar_o.size, AXI_SIZE_BEAT);
      if (src_ic && i_ar >= i_list.size()) begin
        fail_note("unexpected icache request on AR");
      end else if (src_ic) begin
        idx = i_list[i_ar];
        i_ar++;
        if (axi_ar_o.addr !== ga[idx]) mismatch("axi_ar_o.addr", axi_ar_o.addr, ga[idx]);
        if (axi_ar_o.len !== 8'd3) mismatch("axi_ar_o.len", axi_ar_o.len, 3);
      end else if (d_ar >= d_list.size()) begin
        fail_note("unexpected dcache request on AR");
      end else begin
        idx = d_list[d_ar];
        d_ar++;
        if (axi_ar_o.addr !== ga[idx]) mismatch("axi_ar_o.addr", axi_ar_o.addr, ga[idx]);
        if (axi_ar_o.id !== gid[idx]) mismatch("axi_ar_o.id", axi_ar_o.id, gid[idx]);
        if (axi_ar_o.len !== 8'(glen[idx])) mismatch("axi_ar_o.len", axi_ar_o.len, glen[idx]);
      end
    end
    if (rst_n && dcache_miss_resp_valid_o && dcache_miss_resp_ready_i) begin
      if (d_rsp >= d_list.size()) begin
        fail_note("dcache response beat with no outstanding request");
      end else begin
        idx = d_list[d_rsp];
        if (dcache_miss_resp_o.data !== {4{gw[idx][d_beat]}})
          mismatch("dcache_miss_resp_o.data", dcache_miss_resp_o.data, {4{gw[idx][d_beat]}});
        if (dcache_miss_resp_o.id !== gid[idx])
          mismatch("dcache_miss_resp_o.id", dcache_miss_resp_o.id, gid[idx]);
        if (dcache_miss_resp_o.err !== ga[idx][12])
          mismatch("dcache_miss_resp_o.err", dcache_miss_resp_o.err, ga[idx][12]);
        if (dcache_miss_resp_o.last !== (d_beat == glen[idx]))
          mismatch("dcache_miss_resp_o.last", dcache_miss_resp_o.last, d_beat == glen[idx]);
        if (d_beat == glen[idx]) begin
          d_rsp++;
          d_beat = 0;
        end else begin
          d_beat++;
        end
      end
    end
    if (rst_n && icache_miss_resp_valid_o) begin
      if (i_rsp >= i_list.size()) begin
        fail_note("icache response pulse with no outstanding request");
      end else begin
        idx = i_list[i_rsp];
        i_rsp++;
        for (int b = 0; b < IFILL_BEATS; b++) line[b*MEM_DATA_W +: MEM_DATA_W] = {4{gw[idx][b]}};
        if (icache_miss_resp_data_o !== line)
          mismatch("icache_miss_resp_data_o", icache_miss_resp_data_o, line);
        if (icache_miss_resp_err_o !== ga[idx][12])
          mismatch("icache_miss_resp_err_o", icache_miss_resp_err_o, ga[idx][12]);
      end
    end
  end

  initial begin : watchdog
    wait (golden_loaded && n_lines > 0);
    repeat (200 * n_lines) @(posedge clk);
    $display("Timeout: responses still outstanding after %0d cycles", 200 * n_lines);
    $display("Result: FAILED");
    $finish;
  end

  initial begin : main
    int fd, code;
    string line;
    byte src;
    logic [39:0] a;
    logic [3:0] id_v;
    int l, st;
    logic [31:0] w0, w1, w2, w3;
    void'($urandom(32'h1400_0f15));
    icache_miss_valid_i = 1'b0;
    icache_miss_paddr_i = '0;
    dcache_miss_valid_i = 1'b0;
    dcache_miss_req_i = '0;
    axi_ar_ready_i = 1'b0;
    axi_r_valid_i = 1'b0;
    axi_r_i = '0;
    dcache_miss_resp_ready_i = 1'b0;
    fd = $fopen("bench/read_golden.txt", "r");
    if (fd == 0) begin
      $display("Error: cannot open bench/read_golden.txt");
      $display("Result: FAILED");
      $finish;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        if (code == 0 || line.len() < 4 || line.getc(0) == 8'h23) continue;
        code = $sscanf(line, "%c %h %h %d %d %h %h %h %h", src, a, id_v, l, st, w0, w1, w2, w3);
        if (code != 9) begin
          fail_note("malformed line in golden file");
          continue;
        end
        ga[n_lines] = a;
        gid[n_lines] = id_v;
        glen[n_lines] = l;
        gstl[n_lines] = st;
        gw[n_lines] = '{w0, w1, w2, w3};
        if (src == 8'h49) i_list.push_back(n_lines);
        else d_list.push_back(n_lines);
        n_lines++;
      end
      $fclose(fd);
      if (n_lines == 0) fail_note("golden file holds no requests");
      golden_loaded = 1'b1;
      wait (rst_n);
      @(negedge clk);
      fork
        drive_icache();
        drive_dcache();
      join
      wait (d_rsp == d_list.size() && i_rsp == i_list.size());
      repeat (20) @(posedge clk);
      if (uut.u_props.fail_count != 0) begin
        errors += uut.u_props.fail_count;
        $display("Error at %0t: %0d protocol assertion failures", $time, uut.u_props.fail_count);
      end
      $display("Summary: %0d errors, %0d dcache bursts, %0d icache lines", errors, d_rsp, i_rsp);
      if (errors == 0) begin
        $display("Result: PASSED");
      end else begin
        $display("Result: FAILED");
      end
      $finish;
    end
  end

endmodule

// File: build.f
hw/mem_req_pkg.sv
hw/axi_rd_pkg.sv
hw/read_req_arbiter.sv
hw/r_beat_fifo.sv
hw/read_resp_router.sv
hw/cache_axi_read_top.sv
bench/tb_clk_gen.sv
bench/cache_axi_read_properties.sv
bench/tb_top.sv

// File: hw/axi_rd_pkg.sv
/* AXI4 read channel words and constants used by the bridge.
   Only INCR-style read bursts are produced; no user, lock or cache fields. */
package axi_rd_pkg;

  import mem_req_pkg::*;

  localparam int AXI_LEN_W  = 8;
  localparam int AXI_SIZE_W = 3;
  localparam int AXI_RESP_W = 2;

  localparam logic [AXI_RESP_W-1:0] AXI_RESP_OKAY = 2'b00;
  localparam logic [AXI_SIZE_W-1:0] AXI_SIZE_BEAT = 3'd4;

  // Depth of the R channel buffer
  localparam int R_FIFO_DEPTH = 2;

  typedef struct packed {
    logic [MEM_ID_W-1:0]   id;
    logic [PADDR_W-1:0]    addr;
    logic [AXI_LEN_W-1:0]  len;
    logic [AXI_SIZE_W-1:0] size;
  } axi_ar_t;

  typedef struct packed {
    logic [MEM_ID_W-1:0]   id;
    logic [MEM_DATA_W-1:0] data;
    logic [AXI_RESP_W-1:0] resp;
    logic                  last;
  } axi_r_t;

endpackage

// File: hw/cache_axi_read_top.sv
`timescale 1ns/1ps
/* Read side of the cache-to-AXI bridge: arbiter, R beat buffer and response router.
   Write channels are not present. */
module cache_axi_read_top
  import mem_req_pkg::*;
  import axi_rd_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,

  input  logic               icache_miss_valid_i,
  input  logic [PADDR_W-1:0] icache_miss_paddr_i,
  output logic               icache_miss_ready_o,

  input  logic               dcache_miss_valid_i,
  input  mem_req_t           dcache_miss_req_i,
  output logic               dcache_miss_ready_o,

  output logic               axi_ar_valid_o,
  output axi_ar_t            axi_ar_o,
  input  logic               axi_ar_ready_i,

  input  logic               axi_r_valid_i,
  input  axi_r_t             axi_r_i,
  output logic               axi_r_ready_o,

  output logic               dcache_miss_resp_valid_o,
  output mem_resp_r_t        dcache_miss_resp_o,
  input  logic               dcache_miss_resp_ready_i,

  output logic               icache_miss_resp_valid_o,
  output ifill_line_t        icache_miss_resp_data_o,
  output logic               icache_miss_resp_err_o
);

  logic   fifo_valid;
  logic   fifo_ready;
  axi_r_t fifo_beat;

  read_req_arbiter u_arbiter (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .icache_miss_valid_i (icache_miss_valid_i),
    .icache_miss_paddr_i (icache_miss_paddr_i),
    .icache_miss_ready_o (icache_miss_ready_o),
    .dcache_miss_valid_i (dcache_miss_valid_i),
    .dcache_miss_req_i   (dcache_miss_req_i),
    .dcache_miss_ready_o (dcache_miss_ready_o),
    .axi_ar_valid_o      (axi_ar_valid_o),
    .axi_ar_o            (axi_ar_o),
    .axi_ar_ready_i      (axi_ar_ready_i)
  );

  r_beat_fifo u_r_fifo (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .axi_r_valid_i (axi_r_valid_i),
    .axi_r_i       (axi_r_i),
    .axi_r_ready_o (axi_r_ready_o),
    .fifo_valid_o  (fifo_valid),
    .fifo_beat_o   (fifo_beat),
    .fifo_ready_i  (fifo_ready)
  );

  read_resp_router u_router (
    .clk_i                    (clk_i),
    .rst_ni                   (rst_ni),
    .fifo_valid_i             (fifo_valid),
    .fifo_beat_i              (fifo_beat),
    .fifo_ready_o             (fifo_ready),
    .dcache_miss_resp_valid_o (dcache_miss_resp_valid_o),
    .dcache_miss_resp_o       (dcache_miss_resp_o),
    .dcache_miss_resp_ready_i (dcache_miss_resp_ready_i),
    .icache_miss_resp_valid_o (icache_miss_resp_valid_o),
    .icache_miss_resp_data_o  (icache_miss_resp_data_o),
    .icache_miss_resp_err_o   (icache_miss_resp_err_o)
  );

endmodule

// File: hw/mem_req_pkg.sv
/* Cache-side request and response types for the read bridge.
   Instruction refills always use ICACHE_MEM_ID; the data cache must never issue it. */
package mem_req_pkg;

  localparam int MEM_DATA_W  = 128;
  localparam int IFILL_W     = 512;
  localparam int IFILL_BEATS = IFILL_W / MEM_DATA_W;
  localparam int PADDR_W     = 40;
  localparam int MEM_ID_W    = 4;
  localparam int MEM_LEN_W   = 4;
  localparam int MEM_SIZE_W  = 3;

  localparam logic [MEM_ID_W-1:0] ICACHE_MEM_ID = 4'hF;

  // Burst length is in beats minus one
  typedef struct packed {
    logic [PADDR_W-1:0]    addr;
    logic [MEM_LEN_W-1:0]  len;
    logic [MEM_SIZE_W-1:0] size;
    logic [MEM_ID_W-1:0]   id;
  } mem_req_t;

  typedef struct packed {
    logic [MEM_DATA_W-1:0] data;
    logic [MEM_ID_W-1:0]   id;
    logic                  err;
    logic                  last;
  } mem_resp_r_t;

  typedef logic [IFILL_W-1:0] ifill_line_t;

endpackage

// File: hw/r_beat_fifo.sv
`timescale 1ns/1ps
/* Two-entry buffer on the AXI R channel. Beats appear at the output one cycle
   after acceptance; there is no bypass path. */
module r_beat_fifo
  import axi_rd_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,

  input  logic   axi_r_valid_i,
  input  axi_r_t axi_r_i,
  output logic   axi_r_ready_o,

  output logic   fifo_valid_o,
  output axi_r_t fifo_beat_o,
  input  logic   fifo_ready_i
);

  localparam int PTR_W = $clog2(R_FIFO_DEPTH);
  localparam int CNT_W = $clog2(R_FIFO_DEPTH + 1);

  axi_r_t             mem_q [R_FIFO_DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  logic [CNT_W-1:0]   count_q;
  logic               push;
  logic               pop;

  assign axi_r_ready_o = (count_q != CNT_W'(R_FIFO_DEPTH));
  assign fifo_valid_o  = (count_q != '0);
  assign fifo_beat_o   = mem_q[rd_ptr_q];

  assign push = axi_r_valid_i & axi_r_ready_o;
  assign pop  = fifo_valid_o & fifo_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= axi_r_i;
  end

endmodule

// File: hw/read_req_arbiter.sv
`timescale 1ns/1ps
/* Round-robin arbiter between icache refills and dcache misses onto one AR channel.
   The icache may withdraw valid at any time; the dcache request must hold until ready. */
module read_req_arbiter
  import mem_req_pkg::*;
  import axi_rd_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_ni,

  input  logic               icache_miss_valid_i,
  input  logic [PADDR_W-1:0] icache_miss_paddr_i,
  output logic               icache_miss_ready_o,

  input  logic               dcache_miss_valid_i,
  input  mem_req_t           dcache_miss_req_i,
  output logic               dcache_miss_ready_o,

  output logic               axi_ar_valid_o,
  output axi_ar_t            axi_ar_o,
  input  logic               axi_ar_ready_i
);

  mem_req_t ic_req_q;
  logic     ic_valid_q;
  logic     ic_take;

  // High when the icache entry wins a tie
  logic     rr_ic_q;
  logic     ar_free;
  logic     grant_ic;
  logic     grant_dc;
  mem_req_t sel_req;

  axi_ar_t  ar_q;
  logic     ar_valid_q;

  // Holding register makes the icache request stable for AXI
  assign icache_miss_ready_o = ~ic_valid_q;
  assign ic_take             = icache_miss_valid_i & ~ic_valid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ic_valid_q <= 1'b0;
    end else if (ic_take) begin
      ic_valid_q <= 1'b1;
    end else if (grant_ic) begin
      ic_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ic_take) begin
      ic_req_q.addr <= icache_miss_paddr_i;
      ic_req_q.len  <= MEM_LEN_W'(IFILL_BEATS - 1);
      ic_req_q.size <= AXI_SIZE_BEAT;
      ic_req_q.id   <= ICACHE_MEM_ID;
    end
  end

  // AR slot can take a new request when empty or draining this cycle
  assign ar_free = ~ar_valid_q | axi_ar_ready_i;

  assign grant_ic            = ar_free & ic_valid_q & (rr_ic_q | ~dcache_miss_valid_i);
  assign dcache_miss_ready_o = ar_free & ~(ic_valid_q & rr_ic_q);
  assign grant_dc            = dcache_miss_valid_i & dcache_miss_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rr_ic_q <= 1'b0;
    end else if (grant_ic | grant_dc) begin
      rr_ic_q <= grant_dc;
    end
  end

  assign sel_req = grant_ic ? ic_req_q : dcache_miss_req_i;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      ar_valid_q <= 1'b0;
    end else if (ar_free) begin
      ar_valid_q <= grant_ic | grant_dc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (grant_ic | grant_dc) begin
      ar_q.id   <= sel_req.id;
      ar_q.addr <= sel_req.addr;
      ar_q.len  <= AXI_LEN_W'(sel_req.len);
      ar_q.size <= sel_req.size;
    end
  end

  assign axi_ar_valid_o = ar_valid_q;
  assign axi_ar_o       = ar_q;

endmodule

// File: hw/read_resp_router.sv
`timescale 1ns/1ps
/* Steers R beats by ID. Dcache beats pass through with back-pressure; icache beats
   are always taken and packed into a 512-bit line, beat 0 in the low bits. */
module read_resp_router
  import mem_req_pkg::*;
  import axi_rd_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,

  input  logic        fifo_valid_i,
  input  axi_r_t      fifo_beat_i,
  output logic        fifo_ready_o,

  output logic        dcache_miss_resp_valid_o,
  output mem_resp_r_t dcache_miss_resp_o,
  input  logic        dcache_miss_resp_ready_i,

  output logic        icache_miss_resp_valid_o,
  output ifill_line_t icache_miss_resp_data_o,
  output logic        icache_miss_resp_err_o
);

  localparam int BEAT_CNT_W = $clog2(IFILL_BEATS);

  logic                  is_ic;
  logic                  beat_err;
  logic                  ic_take;
  logic                  err_acc;
  logic [BEAT_CNT_W-1:0] beat_cnt_q;
  logic                  err_q;
  logic                  ic_valid_q;
  ifill_line_t           line_q;

  assign is_ic    = (fifo_beat_i.id == ICACHE_MEM_ID);
  assign beat_err = (fifo_beat_i.resp != AXI_RESP_OKAY);

  // Icache side has no ready, so its beats never stall the FIFO
  assign fifo_ready_o = is_ic | dcache_miss_resp_ready_i;

  assign dcache_miss_resp_valid_o = fifo_valid_i & ~is_ic;
  assign dcache_miss_resp_o.data  = fifo_beat_i.data;
  assign dcache_miss_resp_o.id    = fifo_beat_i.id;
  assign dcache_miss_resp_o.err   = beat_err;
  assign dcache_miss_resp_o.last  = fifo_beat_i.last;

  assign ic_take = fifo_valid_i & is_ic;

  // Error flag restarts on the first beat of each line
  assign err_acc = ((beat_cnt_q == '0) ? 1'b0 : err_q) | beat_err;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      beat_cnt_q <= '0;
      err_q      <= 1'b0;
      ic_valid_q <= 1'b0;
    end else begin
      ic_valid_q <= ic_take & fifo_beat_i.last;
      if (ic_take) begin
        err_q      <= err_acc;
        beat_cnt_q <= fifo_beat_i.last ? '0 : beat_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (ic_take) begin
      line_q[beat_cnt_q*MEM_DATA_W +: MEM_DATA_W] <= fifo_beat_i.data;
    end
  end

  assign icache_miss_resp_valid_o = ic_valid_q;
  assign icache_miss_resp_data_o  = line_q;
  assign icache_miss_resp_err_o   = err_q;

endmodule

// File: run.sh
#!/bin/sh
# Build and run the read bridge testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f build.f -o sim_tb
./obj_dir/sim_tb | tee sim.log
if grep -q "Result: PASSED" sim.log; then
  exit 0
else
  exit 1
fi
